//--- src/bp_cfg_pkg.sv
package bp_cfg_pkg;

    // Fetch address width
    localparam int unsigned xlen = 32;

    // Global history length in resolved branches
    localparam int unsigned ghr_bits = 4;

    // One two-bit counter per history pattern
    localparam int unsigned pht_entries = 2 ** ghr_bits;

    // Direct-mapped BTB, 16 entries
    localparam int unsigned btb_index_bits = 4;

    // Tag is what is left above the index and the byte offset
    localparam int unsigned btb_tag_bits = xlen - btb_index_bits - 2;

    // Correction table, 16 entries
    localparam int unsigned bcb_index_bits = 4;

    // Fetch starts here after reset
    localparam logic [xlen-1:0] reset_pc = '0;

    // Sequential fetch step, one 32-bit instruction
    localparam logic [xlen-1:0] inst_bytes = 4;

    // Counters come up weakly not taken
    localparam logic [1:0] ctr_reset = 2'b01;

endpackage

//--- src/bp_types_pkg.sv
package bp_types_pkg;

    import bp_cfg_pkg::*;

    // Address split used by the BTB and the correction table
    // Tag on top, table index in the middle
    typedef struct packed {
        logic [btb_tag_bits-1:0]   tag;
        logic [btb_index_bits-1:0] index;
        // Always zero for aligned fetch
        logic [1:0]                offset;
    } fetch_addr_fields_t;

    // One fetch address word, two decodings
    // raw for PC arithmetic and redirect values
    // fields for table lookup
    typedef union packed {
        logic [xlen-1:0]    raw;
        fetch_addr_fields_t fields;
    } fetch_addr_u;

endpackage

//--- src/global_history_register.sv
module global_history_register (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          ex_branch,
    input  logic                          pcsrc,
    output logic [bp_cfg_pkg::ghr_bits-1:0] branch_history
);

    import bp_cfg_pkg::*;

    // Outcome history of the last ghr_bits resolved branches
    logic [ghr_bits-1:0] history_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // Empty history after reset
            history_q <= '0;
        end else if (ex_branch) begin
            // Newest outcome enters at bit 0
            // oldest one drops off the top
            history_q <= {history_q[ghr_bits-2:0], pcsrc};
        end
    end

    // Path context for the counter table
    assign branch_history = history_q;

endmodule

//--- src/pattern_history_table.sv
module pattern_history_table (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            ex_branch,
    input  logic                            pcsrc,
    input  logic [bp_cfg_pkg::ghr_bits-1:0] branch_history,
    output logic                            taken
);

    import bp_cfg_pkg::*;

    // Two-bit saturating counters
    // 00 strong not taken, 01 weak not taken
    // 10 weak taken, 11 strong taken
    logic [1:0] ctr_q [pht_entries];

    // Counter picked by the current history
    logic [1:0] sel_ctr;

    // Pure global scheme, history is the whole index
    assign sel_ctr = ctr_q[branch_history];

    // Predict taken in either taken state
    assign taken = sel_ctr[1];

    // History only moves at the edge
    // so the read index is also the update index
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < pht_entries; i++) begin
                ctr_q[i] <= ctr_reset;
            end
        end else if (ex_branch) begin
            if (pcsrc) begin
                // Count up, stop at strong taken
                if (sel_ctr != 2'b11) begin
                    ctr_q[branch_history] <= sel_ctr + 2'd1;
                end
            end else begin
                // Count down, stop at strong not taken
                if (sel_ctr != 2'b00) begin
                    ctr_q[branch_history] <= sel_ctr - 2'd1;
                end
            end
        end
    end

endmodule

//--- src/branch_target_buffer.sv
module branch_target_buffer (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        ex_branch,
    input  logic                        pcsrc,
    input  logic [bp_cfg_pkg::xlen-1:0] ex_pc,
    input  logic [bp_cfg_pkg::xlen-1:0] pc_branch,
    input  logic [bp_cfg_pkg::xlen-1:0] pc,
    output logic [bp_cfg_pkg::xlen-1:0] pc_target,
    output logic                        hit
);

    import bp_cfg_pkg::*;
    import bp_types_pkg::*;

    localparam int unsigned entries = 2 ** btb_index_bits;

    // Fetch side and resolve side views of the address
    fetch_addr_u fetch_addr;
    fetch_addr_u ex_addr;

    // Entry state
    logic                    valid_q  [entries];
    logic [btb_tag_bits-1:0] tag_q    [entries];
    logic [xlen-1:0]         target_q [entries];

    // Lookup and update indices
    logic [btb_index_bits-1:0] rd_idx;
    logic [btb_index_bits-1:0] wr_idx;

    // Allocate only on a taken branch
    logic alloc;

    assign fetch_addr.raw = pc;
    assign ex_addr.raw    = ex_pc;

    assign rd_idx = fetch_addr.fields.index;
    assign wr_idx = ex_addr.fields.index;

    assign alloc = ex_branch && pcsrc;

    // Valid bits are the only state cleared by reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < entries; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (alloc) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Tag and target follow the valid bit
    // last taken branch at an index replaces the old one
    always_ff @(posedge clk) begin
        if (alloc) begin
            tag_q[wr_idx]    <= ex_addr.fields.tag;
            target_q[wr_idx] <= pc_branch;
        end
    end

    // Same-cycle lookup for the current fetch address
    assign hit = valid_q[rd_idx] && (tag_q[rd_idx] == fetch_addr.fields.tag);

    // Target is meaningful only together with hit
    assign pc_target = target_q[rd_idx];

endmodule

//--- src/branch_correction_buffer.sv
module branch_correction_buffer (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic [bp_cfg_pkg::xlen-1:0] pc,
    input  logic                        pc_taken,
    input  logic [bp_cfg_pkg::xlen-1:0] pc_target,
    input  logic                        ex_branch,
    input  logic                        pcsrc,
    input  logic [bp_cfg_pkg::xlen-1:0] ex_pc,
    input  logic [bp_cfg_pkg::xlen-1:0] pc_branch,
    output logic [bp_cfg_pkg::xlen-1:0] pc_reverse,
    output logic                        wrong
);

    import bp_cfg_pkg::*;
    import bp_types_pkg::*;

    localparam int unsigned entries = 2 ** bcb_index_bits;

    fetch_addr_u fetch_addr;
    fetch_addr_u ex_addr;

    // One record per fetched address
    logic            valid_q [entries];
    logic [xlen-1:0] pc_q    [entries];
    logic            dir_q   [entries];

    logic [bcb_index_bits-1:0] rec_idx;
    logic [bcb_index_bits-1:0] chk_idx;

    // Fall-through address of the current fetch
    logic [xlen-1:0] seq_pc;
    // Direction fetch actually followed
    logic            pred_dir;
    // Resolving branch has a live record
    logic            match;

    assign fetch_addr.raw = pc;
    assign ex_addr.raw    = ex_pc;

    assign rec_idx = fetch_addr.fields.index;
    assign chk_idx = ex_addr.fields.index;

    assign seq_pc = fetch_addr.raw + inst_bytes;

    // A taken redirect onto the fall-through is still the sequential path
    assign pred_dir = pc_taken && (pc_target != seq_pc);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < entries; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else begin
            // Resolved record is retired
            if (ex_branch) begin
                valid_q[chk_idx] <= 1'b0;
            end
            // New fetch wins when both hit the same entry
            valid_q[rec_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        pc_q[rec_idx]  <= fetch_addr.raw;
        dir_q[rec_idx] <= pred_dir;
    end

    // Full address compare, no aliasing between entries
    assign match = valid_q[chk_idx] && (pc_q[chk_idx] == ex_addr.raw);

    // Recorded guess disagrees with the real outcome
    assign wrong = ex_branch && match && (dir_q[chk_idx] != pcsrc);

    // Correct path for the resolving branch
    assign pc_reverse = pcsrc ? pc_branch : ex_addr.raw + inst_bytes;

endmodule

//--- src/fetch_pc_unit.sv
module fetch_pc_unit (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        taken,
    input  logic                        hit,
    input  logic [bp_cfg_pkg::xlen-1:0] pc_target,
    input  logic                        wrong,
    input  logic [bp_cfg_pkg::xlen-1:0] pc_reverse,
    input  logic                        ex_jump,
    input  logic                        ex_branch,
    input  logic                        pcsrc,
    input  logic                        ex_hit,
    input  logic [bp_cfg_pkg::xlen-1:0] pc_branch,
    input  logic                        mret_sig,
    input  logic                        exception_sig,
    input  logic [bp_cfg_pkg::xlen-1:0] csr_epc,
    input  logic [bp_cfg_pkg::xlen-1:0] ehr_address,
    output logic [bp_cfg_pkg::xlen-1:0] pc,
    output logic                        pc_taken,
    output logic                        first_and_pcsrc
);

    import bp_cfg_pkg::*;
    import bp_types_pkg::*;

    fetch_addr_u pc_q;
    fetch_addr_u next_pc;

    // Resolve-side redirect to the computed target
    logic ex_redirect;

    // Predictor redirect needs both a taken guess and a known target
    assign pc_taken = taken && hit;

    // Taken branch that fetch had no target for
    assign first_and_pcsrc = ex_branch && pcsrc && !ex_hit;

    // Jumps always go to the computed target
    assign ex_redirect = ex_jump || first_and_pcsrc;

    // Next fetch address by priority
    always_comb begin
        if (exception_sig) begin
            // Trap entry beats everything, mret included
            next_pc.raw = ehr_address;
        end else if (mret_sig) begin
            next_pc.raw = csr_epc;
        end else if (ex_redirect) begin
            next_pc.raw = pc_branch;
        end else if (wrong) begin
            // Misprediction repair from EX
            next_pc.raw = pc_reverse;
        end else if (pc_taken) begin
            next_pc.raw = pc_target;
        end else begin
            // Plain sequential fetch
            next_pc.raw = pc_q.raw + inst_bytes;
        end
    end

    // No stalls, PC loads every cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q.raw <= reset_pc;
        end else begin
            pc_q <= next_pc;
        end
    end

    assign pc = pc_q.raw;

endmodule

//--- src/global_prediction_top.sv
module global_prediction_top (
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        ex_branch,
    input  logic                        pcsrc,
    input  logic [bp_cfg_pkg::xlen-1:0] ex_pc,
    input  logic [bp_cfg_pkg::xlen-1:0] pc_branch,
    input  logic                        ex_jump,
    input  logic                        ex_hit,
    input  logic [bp_cfg_pkg::xlen-1:0] csr_epc,
    input  logic [bp_cfg_pkg::xlen-1:0] ehr_address,
    input  logic                        mret_sig,
    input  logic                        exception_sig,
    output logic [bp_cfg_pkg::xlen-1:0] pc,
    output logic                        wrong,
    output logic                        first_and_pcsrc,
    output logic                        hit,
    output logic                        pc_taken
);

    import bp_cfg_pkg::*;

    // History into the counter table
    logic [ghr_bits-1:0] branch_history;
    // Direction guess for the current history
    logic                taken;
    // Stored target for the current pc
    logic [xlen-1:0]     pc_target;
    // Correct path after a misprediction
    logic [xlen-1:0]     pc_reverse;

    global_history_register u_ghr (
        .clk            (clk),
        .arst_n         (arst_n),
        .ex_branch      (ex_branch),
        .pcsrc          (pcsrc),
        .branch_history (branch_history)
    );

    pattern_history_table u_pht (
        .clk            (clk),
        .arst_n         (arst_n),
        .ex_branch      (ex_branch),
        .pcsrc          (pcsrc),
        .branch_history (branch_history),
        .taken          (taken)
    );

    // Target lookup runs off the live fetch pc
    branch_target_buffer u_btb (
        .clk       (clk),
        .arst_n    (arst_n),
        .ex_branch (ex_branch),
        .pcsrc     (pcsrc),
        .ex_pc     (ex_pc),
        .pc_branch (pc_branch),
        .pc        (pc),
        .pc_target (pc_target),
        .hit       (hit)
    );

    // Records what fetch did, checks it when EX resolves
    branch_correction_buffer u_bcb (
        .clk        (clk),
        .arst_n     (arst_n),
        .pc         (pc),
        .pc_taken   (pc_taken),
        .pc_target  (pc_target),
        .ex_branch  (ex_branch),
        .pcsrc      (pcsrc),
        .ex_pc      (ex_pc),
        .pc_branch  (pc_branch),
        .pc_reverse (pc_reverse),
        .wrong      (wrong)
    );

    fetch_pc_unit u_pcu (
        .clk             (clk),
        .arst_n          (arst_n),
        .taken           (taken),
        .hit             (hit),
        .pc_target       (pc_target),
        .wrong           (wrong),
        .pc_reverse      (pc_reverse),
        .ex_jump         (ex_jump),
        .ex_branch       (ex_branch),
        .pcsrc           (pcsrc),
        .ex_hit          (ex_hit),
        .pc_branch       (pc_branch),
        .mret_sig        (mret_sig),
        .exception_sig   (exception_sig),
        .csr_epc         (csr_epc),
        .ehr_address     (ehr_address),
        .pc              (pc),
        .pc_taken        (pc_taken),
        .first_and_pcsrc (first_and_pcsrc)
    );

endmodule

//--- tb/global_prediction_checker.sv
module global_prediction_checker (
    input logic                        clk,
    input logic                        arst_n,
    input logic                        pc_taken,
    input logic                        hit,
    input logic [bp_cfg_pkg::xlen-1:0] pc_target,
    input logic                        exception_sig,
    input logic                        mret_sig,
    input logic                        ex_jump,
    input logic                        first_and_pcsrc,
    input logic [bp_cfg_pkg::xlen-1:0] ehr_address,
    input logic [bp_cfg_pkg::xlen-1:0] pc,
    input logic                        wrong,
    input logic                        ex_branch,
    input logic                        pcsrc,
    input logic [bp_cfg_pkg::xlen-1:0] ex_pc,
    input logic [bp_cfg_pkg::xlen-1:0] pc_branch
);
    timeunit 1ns;
    timeprecision 1ps;

    import bp_cfg_pkg::*;

    // Read by the testbench at the end of the run
    int unsigned assert_failures = 0;

    // Trap, mret or EX target redirect outranks the predictor
    logic ex_override;

    assign ex_override = exception_sig || mret_sig || ex_jump || first_and_pcsrc;

    // Predictor redirect only with a known target
    // and fetch lands on that target one edge later
    taken_needs_hit: assert property (@(posedge clk) disable iff (!arst_n)
        pc_taken && !ex_override && !wrong |-> hit ##1 (pc == $past(pc_target)))
        else begin
            $error("pc_taken redirect did not reach the BTB target");
            assert_failures++;
        end

    // Trap entry lands on the vector one edge later
    trap_entry: assert property (@(posedge clk) disable iff (!arst_n)
        exception_sig |=> (pc == $past(ehr_address)))
        else begin
            $error("pc did not follow ehr_address after exception_sig");
            assert_failures++;
        end

    // Mispredict flag only on a resolving branch
    // Repair goes to the real path of that branch
    wrong_on_branch: assert property (@(posedge clk) disable iff (!arst_n)
        wrong && !ex_override
        |-> ex_branch ##1 (pc == $past(pcsrc ? pc_branch : ex_pc + inst_bytes)))
        else begin
            $error("wrong did not repair fetch to the resolved path");
            assert_failures++;
        end

endmodule

bind global_prediction_top global_prediction_checker u_checker (
    .clk             (clk),
    .arst_n          (arst_n),
    .pc_taken        (pc_taken),
    .hit             (hit),
    .pc_target       (pc_target),
    .exception_sig   (exception_sig),
    .mret_sig        (mret_sig),
    .ex_jump         (ex_jump),
    .first_and_pcsrc (first_and_pcsrc),
    .ehr_address     (ehr_address),
    .pc              (pc),
    .wrong           (wrong),
    .ex_branch       (ex_branch),
    .pcsrc           (pcsrc),
    .ex_pc           (ex_pc),
    .pc_branch       (pc_branch)
);

//--- tb/global_prediction_tb.sv
module global_prediction_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import bp_cfg_pkg::*;

    localparam int clk_period = 20;
    localparam int btb_size = 2 ** btb_index_bits;
    localparam int bcb_size = 2 ** bcb_index_bits;
    // Reset, seq, miss, training, mispredict, traps, random
    localparam int test_cycles = 10 + 8 + 4 + 15 + 2 + 6 + 302;
    // Branch under training and its target, different table indices
    localparam logic [xlen-1:0] br_addr = 32'h48;
    localparam logic [xlen-1:0] br_tgt = 32'h300;

    logic clk = 1'b0;
    logic arst_n;
    logic ex_branch, pcsrc, ex_jump, ex_hit, mret_sig, exception_sig;
    logic [xlen-1:0] ex_pc, pc_branch, csr_epc, ehr_address;
    logic [xlen-1:0] pc;
    logic wrong, first_and_pcsrc, hit, pc_taken;

    // Reference model state
    logic [ghr_bits-1:0]     m_hist;
    logic [1:0]              m_ctr     [pht_entries];
    logic                    m_btb_v   [btb_size];
    logic [btb_tag_bits-1:0] m_btb_tag [btb_size];
    logic [xlen-1:0]         m_btb_tgt [btb_size];
    logic                    m_bcb_v   [bcb_size];
    logic [xlen-1:0]         m_bcb_pc  [bcb_size];
    logic                    m_bcb_dir [bcb_size];
    logic [xlen-1:0]         exp_pc, m_next;
    logic                    e_hit, e_taken, e_wrong, e_first;
    logic                    checking = 1'b0;
    logic                    seen_wrong, seen_first;

    string test_name = "reset";
    int errors = 0;
    int err_mark = 0;
    int tests_run = 0;
    int tests_failed = 0;

    global_prediction_top DUT (
        .clk(clk), .arst_n(arst_n), .ex_branch(ex_branch), .pcsrc(pcsrc),
        .ex_pc(ex_pc), .pc_branch(pc_branch), .ex_jump(ex_jump), .ex_hit(ex_hit),
        .csr_epc(csr_epc), .ehr_address(ehr_address), .mret_sig(mret_sig),
        .exception_sig(exception_sig), .pc(pc), .wrong(wrong),
        .first_and_pcsrc(first_and_pcsrc), .hit(hit), .pc_taken(pc_taken)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic check_value(input string what, input logic [xlen-1:0] expected,
                               input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic reset_model();
        m_hist = '0;
        for (int i = 0; i < pht_entries; i++) m_ctr[i] = ctr_reset;
        for (int i = 0; i < btb_size; i++) begin
            m_btb_v[i] = 1'b0;
            m_btb_tag[i] = '0;
            m_btb_tgt[i] = '0;
        end
        for (int i = 0; i < bcb_size; i++) begin
            m_bcb_v[i] = 1'b0;
            m_bcb_pc[i] = '0;
            m_bcb_dir[i] = 1'b0;
        end
    endtask

    // One cycle of the predictor, from the current model state and inputs
    function automatic logic [xlen-1:0] predict_next_pc(output logic o_hit,
        output logic o_taken, output logic o_wrong, output logic o_first);
        logic [btb_index_bits-1:0] fi;
        logic [bcb_index_bits-1:0] ri;
        logic [bcb_index_bits-1:0] ci;
        logic [xlen-1:0] seq;
        logic [xlen-1:0] nxt;
        logic dir;
        fi = exp_pc[btb_index_bits+1:2];
        ri = exp_pc[bcb_index_bits+1:2];
        ci = ex_pc[bcb_index_bits+1:2];
        seq = exp_pc + inst_bytes;
        o_hit = m_btb_v[fi] && (m_btb_tag[fi] == exp_pc[xlen-1:btb_index_bits+2]);
        o_taken = o_hit && m_ctr[m_hist][1];
        o_wrong = ex_branch && m_bcb_v[ci] && (m_bcb_pc[ci] == ex_pc)
                  && (m_bcb_dir[ci] != pcsrc);
        o_first = ex_branch && pcsrc && !ex_hit;
        // Taken onto the fall-through counts as sequential
        dir = o_taken && (m_btb_tgt[fi] != seq);
        if (exception_sig) nxt = ehr_address;
        else if (mret_sig) nxt = csr_epc;
        else if (ex_jump || o_first) nxt = pc_branch;
        else if (o_wrong) nxt = pcsrc ? pc_branch : ex_pc + inst_bytes;
        else if (o_taken) nxt = m_btb_tgt[fi];
        else nxt = seq;
        // Training at the resolving edge
        if (ex_branch) begin
            if (pcsrc) begin
                if (m_ctr[m_hist] != 2'b11) m_ctr[m_hist] = m_ctr[m_hist] + 2'd1;
                m_btb_v[ex_pc[btb_index_bits+1:2]] = 1'b1;
                m_btb_tag[ex_pc[btb_index_bits+1:2]] = ex_pc[xlen-1:btb_index_bits+2];
                m_btb_tgt[ex_pc[btb_index_bits+1:2]] = pc_branch;
            end else if (m_ctr[m_hist] != 2'b00) begin
                m_ctr[m_hist] = m_ctr[m_hist] - 2'd1;
            end
            m_bcb_v[ci] = 1'b0;
            m_hist = {m_hist[ghr_bits-2:0], pcsrc};
        end
        // Fetch record wins over retirement
        m_bcb_v[ri] = 1'b1;
        m_bcb_pc[ri] = exp_pc;
        m_bcb_dir[ri] = dir;
        return nxt;
    endfunction

    // Compare at each edge, before the DUT registers update
    always @(posedge clk) begin
        if (checking) begin
            check_value("pc", exp_pc, pc);
            m_next = predict_next_pc(e_hit, e_taken, e_wrong, e_first);
            check_value("hit", e_hit, hit);
            check_value("pc_taken", e_taken, pc_taken);
            check_value("wrong", e_wrong, wrong);
            check_value("first_and_pcsrc", e_first, first_and_pcsrc);
            exp_pc = m_next;
        end
    end

    task automatic quiet_inputs();
        ex_branch = 1'b0;
        ex_jump = 1'b0;
        pcsrc = 1'b0;
        ex_hit = 1'b0;
        mret_sig = 1'b0;
        exception_sig = 1'b0;
        ex_pc = '0;
        pc_branch = '0;
    endtask

    // EX event for one cycle, flags sampled at the edge
    task automatic resolve(input logic is_jump, input logic outcome,
        input logic [xlen-1:0] addr, input logic [xlen-1:0] target, input logic carried_hit);
        @(negedge clk);
        ex_branch = !is_jump;
        ex_jump = is_jump;
        pcsrc = outcome;
        ex_pc = addr;
        pc_branch = target;
        ex_hit = carried_hit;
        @(posedge clk);
        seen_wrong = wrong;
        seen_first = first_and_pcsrc;
        @(negedge clk);
        quiet_inputs();
    endtask

    task automatic trap(input logic exc, input logic ret, input logic [xlen-1:0] vec,
                        input logic [xlen-1:0] epc);
        @(negedge clk);
        exception_sig = exc;
        mret_sig = ret;
        ehr_address = vec;
        csr_epc = epc;
        @(negedge clk);
        quiet_inputs();
    endtask

    function automatic logic [xlen-1:0] addr_rand();
        return {20'd0, 10'($urandom), 2'b00};
    endfunction

    task automatic random_mix(input int cycles);
        logic [xlen-1:0] last_pc;
        int kind;
        last_pc = pc;
        repeat (cycles) begin
            @(negedge clk);
            kind = $urandom % 16;
            ex_branch = (kind < 5);
            ex_jump = (kind == 5);
            pcsrc = 1'($urandom);
            // Half the time resolve the previous fetch, like a pipeline would
            ex_pc = 1'($urandom) ? last_pc : addr_rand();
            pc_branch = addr_rand();
            ex_hit = 1'($urandom);
            exception_sig = ($urandom % 32) == 0;
            mret_sig = ($urandom % 32) == 0;
            ehr_address = addr_rand();
            csr_epc = addr_rand();
            last_pc = pc;
        end
        @(negedge clk);
        quiet_inputs();
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        err_mark = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == err_mark) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", test_name, errors - err_mark);
        end
    endtask

    initial begin
        logic [xlen-1:0] prev;
        void'($urandom(32'h6bc8_9ca0));
        quiet_inputs();
        csr_epc = '0;
        ehr_address = '0;
        arst_n = 1'b0;
        repeat (10) @(negedge clk);
        reset_model();
        exp_pc = reset_pc;
        arst_n = 1'b1;
        checking = 1'b1;

        begin_test("reset");
        check_value("pc", reset_pc, pc);
        check_value("wrong", 0, wrong);
        check_value("hit", 0, hit);
        check_value("pc_taken", 0, pc_taken);
        end_test();

        begin_test("sequential fetch");
        prev = pc;
        repeat (8) begin
            @(negedge clk);
            check_value("pc", prev + inst_bytes, pc);
            prev = pc;
        end
        end_test();

        begin_test("btb miss redirect");
        resolve(1'b0, 1'b1, 32'h80, 32'h100, 1'b0);
        check_value("first_and_pcsrc", 1, seen_first);
        check_value("pc", 32'h100, pc);
        resolve(1'b1, 1'b1, 32'h90, 32'h180, 1'b0);
        check_value("pc", 32'h180, pc);
        end_test();

        // Six taken outcomes saturate the counter behind history 1111
        begin_test("training and prediction");
        repeat (6) resolve(1'b0, 1'b1, br_addr, br_tgt, 1'b1);
        resolve(1'b1, 1'b1, 32'h0, br_addr, 1'b0);
        check_value("pc", br_addr, pc);
        check_value("hit", 1, hit);
        check_value("pc_taken", 1, pc_taken);
        @(negedge clk);
        check_value("pc", br_tgt, pc);
        end_test();

        begin_test("misprediction");
        resolve(1'b0, 1'b0, br_addr, br_tgt, 1'b1);
        check_value("wrong", 1, seen_wrong);
        check_value("pc", br_addr + inst_bytes, pc);
        end_test();

        begin_test("traps");
        trap(1'b1, 1'b0, 32'h1000, 32'h2000);
        check_value("pc", 32'h1000, pc);
        trap(1'b0, 1'b1, 32'h1000, 32'h2000);
        check_value("pc", 32'h2000, pc);
        trap(1'b1, 1'b1, 32'h1000, 32'h2000);
        check_value("pc", 32'h1000, pc);
        end_test();

        begin_test("random mix");
        random_mix(300);
        end_test();

        $display("%0d tests, %0d failed, %0d mismatches, %0d assertion failures",
                 tests_run, tests_failed, errors, DUT.u_checker.assert_failures);
        if (tests_failed == 0 && DUT.u_checker.assert_failures == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Twice the expected length of all tests
    initial begin
        #(2 * test_cycles * clk_period);
        $display("Timeout: the run did not finish within %0d ns",
                 2 * test_cycles * clk_period);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- list.f
src/bp_cfg_pkg.sv
src/bp_types_pkg.sv
src/global_history_register.sv
src/pattern_history_table.sv
src/branch_target_buffer.sv
src/branch_correction_buffer.sv
src/fetch_pc_unit.sv
src/global_prediction_top.sv
tb/global_prediction_checker.sv
tb/global_prediction_tb.sv

//--- Bender.yml
package:
  name: global_prediction

sources:
  - src/bp_cfg_pkg.sv
  - src/bp_types_pkg.sv
  - src/global_history_register.sv
  - src/pattern_history_table.sv
  - src/branch_target_buffer.sv
  - src/branch_correction_buffer.sv
  - src/fetch_pc_unit.sv
  - src/global_prediction_top.sv
  - target: test
    files:
      - tb/global_prediction_checker.sv
      - tb/global_prediction_tb.sv
